/* build.f */
+incdir+.
yuv_pkg.sv
plane_fifo.sv
rd_addr_gen.sv
rdata_demux.sv
yuv_out_stage.sv
yuv_frame_reader.sv
tb_checker.sv
tb_yuv_frame_reader.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the frame reader testbench, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f build.f --top-module tb_yuv_frame_reader -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "Result: FAIL"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "Result: no pass line in sim.log"; exit 1; }
echo "Result: PASS"

/* tb_yuv_frame_reader.sv */
`include "yuv_defines.svh"

module tb_yuv_frame_reader
    import yuv_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] SEED = 32'hc4b2_6097;
    localparam int TIMEOUT = 5000;

    logic                   clk = 1'b0;
    logic                   rst_n = 1'b0;
    logic                   start = 1'b0;
    logic [`YUV_ADDR_W-1:0] base_addr = '0;
    logic [`YUV_ADDR_W-1:0] frame_groups = '0;
    logic                   ar_valid, r_ready, busy, frame_done, rd_error, out_valid;
    logic                   ar_ready = 1'b0;
    logic                   r_valid = 1'b0;
    logic                   out_ready = 1'b0;
    axi_ar_t                ar;
    axi_r_t                 r = '0;
    yuv_group_t             out_group;

    // Slave memory and random sources
    logic [31:0] mem [256];
    logic [31:0] rng;
    logic [31:0] bp_rng;
    logic [31:0] rnd;
    logic [31:0] baddr;
    logic [7:0]  err_word;
    logic        bp_on = 1'b0;
    logic        stalled = 1'b0;
    logic [31:0] ar_q [$];
    int          beat_idx;
    int          tb_errors;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    yuv_frame_reader dut0 (.*);
    tb_checker chk0 (.*);

    always #10 clk = ~clk;

    // ------------------------------------------------------------------------
    // AXI read slave, two bursts queued, beats returned in order
    // ------------------------------------------------------------------------

    always @(posedge clk) begin
        if (!rst_n) begin
            ar_ready  <= 1'b0;
            r_valid   <= 1'b0;
            out_ready <= 1'b0;
            bp_rng    <= SEED;
            beat_idx = 0;
            ar_q.delete();
        end else begin
            rnd = xorshift32(bp_rng);
            bp_rng <= rnd;
            if (r_valid && r_ready) begin
                if (beat_idx == `YUV_BURST_BEATS - 1) begin
                    void'(ar_q.pop_front());
                    beat_idx = 0;
                end else begin
                    beat_idx = beat_idx + 1;
                end
            end
            if (ar_valid && ar_ready) begin
                ar_q.push_back(ar.addr);
            end
            ar_ready <= (ar_q.size() < `YUV_MAX_OUTSTANDING) && (rnd[1:0] != 2'b00);
            // Payload only moves once the current beat is taken
            if (!r_valid || r_ready) begin
                if (ar_q.size() > 0 && rnd[3:2] != 2'b00) begin
                    baddr = ar_q[0] + 32'(4 * beat_idx);
                    r_valid <= 1'b1;
                    r.data  <= mem[baddr[9:2]];
                    r.id    <= '0;
                    r.resp  <= (baddr[9:2] == err_word) ? 2'b10 : 2'b00;
                    r.last  <= (beat_idx == `YUV_BURST_BEATS - 1);
                end else begin
                    r_valid <= 1'b0;
                end
            end
            out_ready <= bp_on ? rnd[8] : 1'b1;
        end
    end

    task automatic run_frame(input int num, input logic [31:0] base, input int groups,
                             input logic busy_start);
        int cycles;
        start        <= 1'b1;
        base_addr    <= base;
        frame_groups <= 32'(groups);
        @(posedge clk);
        // Second start cycle lands while busy
        if (busy_start) begin
            @(posedge clk);
        end
        start <= 1'b0;
        cycles = 0;
        while (!frame_done && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (!frame_done) begin
            $display("Timeout: frame %0d stalled, no frame_done in %0d cycles", num, TIMEOUT);
            stalled = 1'b1;
            tb_errors++;
            return;
        end
        cycles = 0;
        while ((chk0.got_cnt < groups || out_valid) && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (chk0.got_cnt < groups || out_valid) begin
            $display("Timeout: frame %0d stalled with %0d of %0d groups delivered",
                     num, chk0.got_cnt, groups);
            stalled = 1'b1;
            tb_errors++;
            return;
        end
        repeat (4) @(posedge clk);
    endtask

    initial begin
        rng = SEED;
        for (int i = 0; i < 256; i++) begin
            rng = xorshift32(rng);
            mem[i] = rng;
        end
        // SLVERR word inside frame 3, never its final beat
        rng = xorshift32(rng);
        err_word = 8'd96 + 8'(rng % 29);
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        run_frame(1, 32'h0000_0000, 8, 1'b0);
        if (!stalled) begin
            run_frame(2, 32'h0000_0100, 5, 1'b1);
        end
        if (!stalled) begin
            bp_on <= 1'b1;
            run_frame(3, 32'h0000_0180, 10, 1'b0);
        end
        if (chk0.err_rises != 1) begin
            $display("rd_error rose %0d times, once was expected for the SLVERR beat",
                     chk0.err_rises);
            tb_errors++;
        end
        $display("Errors: %0d from the checker, %0d from the testbench",
                 chk0.err_count, tb_errors);
        if (chk0.err_count == 0 && tb_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* tb_checker.sv */
`include "yuv_defines.svh"

module tb_checker
    import yuv_pkg::*;
(
    input logic                   clk, rst_n, start, busy, frame_done, rd_error,
    input logic [`YUV_ADDR_W-1:0] base_addr, frame_groups,
    input axi_ar_t                ar,
    input logic                   ar_valid, ar_ready,
    input axi_r_t                 r,
    input logic                   r_valid, r_ready,
    input yuv_group_t             out_group,
    input logic                   out_valid, out_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] exp_base;
    int          exp_groups;
    int          got_cnt;
    int          ar_cnt;
    int          beat_pos;
    int          err_count;
    int          err_rises;
    logic        frame_open;
    logic        exp_err;
    logic        rd_error_q;

    task automatic report_fail(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        err_count++;
    endtask

    // Group g is three consecutive words from base + 12g
    task automatic check_group(input int g, input yuv_group_t got);
        logic [7:0] w;
        yuv_group_t want;
        w = exp_base[9:2] + 8'(3 * g);
        want.y0 = tb_yuv_frame_reader.mem[w];
        want.y1 = tb_yuv_frame_reader.mem[w + 8'd1];
        want.uv = tb_yuv_frame_reader.mem[w + 8'd2];
        if (got !== want) begin
            report_fail($sformatf("group %0d is %h %h %h, expected %h %h %h", g,
                        got.y0, got.y1, got.uv, want.y0, want.y1, want.uv));
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            exp_base   <= '0;
            exp_groups <= 0;
            got_cnt    <= 0;
            ar_cnt     <= 0;
            beat_pos   <= 0;
            frame_open <= 1'b0;
            exp_err    <= 1'b0;
            rd_error_q <= 1'b0;
        end else begin
            // Start while busy leaves the frame untouched
            if (start && !busy) begin
                exp_base   <= base_addr;
                exp_groups <= int'(frame_groups);
                got_cnt    <= 0;
                ar_cnt     <= 0;
                frame_open <= 1'b1;
            end
            if (ar_valid && ar_ready) begin
                if (ar_cnt >= exp_groups) begin
                    report_fail("AR issued beyond the frame length");
                end else if (ar.addr !== exp_base + 32'(12 * ar_cnt) ||
                             ar.len != 8'(`YUV_BURST_BEATS - 1) || ar.burst != 2'b01 ||
                             ar.size != 3'd2 || ar.id != '0) begin
                    report_fail($sformatf("AR %0d has addr %h len %0d size %0d id %0d",
                                ar_cnt, ar.addr, ar.len, ar.size, ar.id));
                end
                ar_cnt <= ar_cnt + 1;
            end
            if (out_valid && out_ready) begin
                if (got_cnt >= exp_groups) begin
                    report_fail($sformatf("extra group %0d in a frame of %0d",
                                got_cnt, exp_groups));
                end else begin
                    check_group(got_cnt, out_group);
                end
                got_cnt <= got_cnt + 1;
            end
            if (!busy && ar_valid) begin
                report_fail("ar_valid high while idle");
            end
            if (!busy && out_valid && got_cnt >= exp_groups) begin
                report_fail("out_valid high with no group pending");
            end
            if (frame_done) begin
                if (!frame_open || busy || ar_cnt != exp_groups) begin
                    report_fail($sformatf("frame_done with open=%0b busy=%0b after %0d ARs",
                                frame_open, busy, ar_cnt));
                end
                frame_open <= 1'b0;
            end
            // Beats one and two of a group are never stalled
            if (r_valid && !r_ready && beat_pos != 0) begin
                report_fail($sformatf("r_ready low on beat %0d of a group", beat_pos));
            end
            // rd_error follows the last accepted beat
            if (rd_error !== exp_err) begin
                report_fail($sformatf("rd_error is %0b, expected %0b", rd_error, exp_err));
            end
            if (r_valid && r_ready) begin
                exp_err  <= (r.resp != 2'b00);
                beat_pos <= (beat_pos == `YUV_BURST_BEATS - 1) ? 0 : beat_pos + 1;
            end
            if (rd_error && !rd_error_q) begin
                err_rises <= err_rises + 1;
            end
            rd_error_q <= rd_error;
        end
    end

endmodule

/* yuv_frame_reader.sv */
`include "yuv_defines.svh"

module yuv_frame_reader
    import yuv_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic [`YUV_ADDR_W-1:0] base_addr,
    input  logic [`YUV_ADDR_W-1:0] frame_groups,
    output axi_ar_t                ar,
    output logic                   ar_valid,
    input  logic                   ar_ready,
    input  axi_r_t                 r,
    input  logic                   r_valid,
    output logic                   r_ready,
    output logic                   busy,
    output logic                   frame_done,
    output logic                   rd_error,
    output yuv_group_t             out_group,
    output logic                   out_valid,
    input  logic                   out_ready
);

    logic     burst_done;
    logic     y_push;
    logic     uv_push;
    y_pair_t  y_data;
    uv_word_t uv_data;
    logic     y_full;
    logic     uv_full;
    y_pair_t  y_head;
    uv_word_t uv_head;
    logic     y_empty;
    logic     uv_empty;
    logic     pop;

    // -----------------------------------------------------------------------
    // Address and read-data stages
    // -----------------------------------------------------------------------

    rd_addr_gen u_addr (
        .clk, .rst_n, .start, .base_addr, .frame_groups, .burst_done,
        .ar, .ar_valid, .ar_ready, .busy, .frame_done
    );

    rdata_demux u_rdata (
        .clk, .rst_n, .start, .r, .r_valid, .r_ready,
        .y_full, .uv_full, .y_push, .uv_push, .y_data, .uv_data,
        .burst_done, .rd_error
    );

    // -----------------------------------------------------------------------
    // Plane queues and output
    // -----------------------------------------------------------------------

    plane_fifo #(.T(y_pair_t), .DEPTH(`YUV_FIFO_DEPTH)) u_y_fifo (
        .clk, .rst_n, .push(y_push), .push_data(y_data), .pop,
        .pop_data(y_head), .full(y_full), .empty(y_empty)
    );

    plane_fifo #(.T(uv_word_t), .DEPTH(`YUV_FIFO_DEPTH)) u_uv_fifo (
        .clk, .rst_n, .push(uv_push), .push_data(uv_data), .pop,
        .pop_data(uv_head), .full(uv_full), .empty(uv_empty)
    );

    yuv_out_stage u_out (
        .clk, .rst_n, .y_head, .uv_head, .y_empty, .uv_empty, .pop,
        .out_group, .out_valid, .out_ready
    );

endmodule

/* yuv_out_stage.sv */
module yuv_out_stage
    import yuv_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  y_pair_t    y_head,
    input  uv_word_t   uv_head,
    input  logic       y_empty,
    input  logic       uv_empty,
    output logic       pop,
    output yuv_group_t out_group,
    output logic       out_valid,
    input  logic       out_ready
);

    logic heads_ready;
    logic slot_free;

    // Both planes of a group leave together
    assign heads_ready = !y_empty && !uv_empty;
    // Register is empty or drains this cycle
    assign slot_free   = !out_valid || out_ready;
    assign pop         = heads_ready && slot_free;

    // -----------------------------------------------------------------------
    // Output register
    // -----------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (pop) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Group is held until the consumer takes it
    always_ff @(posedge clk) begin
        if (pop) begin
            out_group.y0 <= y_head.y0;
            out_group.y1 <= y_head.y1;
            out_group.uv <= uv_head.uv;
        end
    end

endmodule

/* rdata_demux.sv */
`include "yuv_defines.svh"

module rdata_demux
    import yuv_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     start,
    input  axi_r_t   r,
    input  logic     r_valid,
    output logic     r_ready,
    input  logic     y_full,
    input  logic     uv_full,
    output logic     y_push,
    output logic     uv_push,
    output y_pair_t  y_data,
    output uv_word_t uv_data,
    output logic     burst_done,
    output logic     rd_error
);

    localparam int CNT_W = $clog2(`YUV_BURST_BEATS);
    localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(`YUV_BURST_BEATS - 1);

    logic [CNT_W-1:0] beat_cnt;
    logic             beat_acc;
    logic             push_q;

    // Room is checked only at a group boundary.
    // A push still in flight counts as taking the last free slot
    assign r_ready    = (beat_cnt != '0) || !(y_full || uv_full || push_q);
    assign beat_acc   = r_valid && r_ready;
    assign burst_done = beat_acc && r.last;
    assign y_push     = push_q;
    assign uv_push    = push_q;

    // Beat position inside the group
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (start) begin
            beat_cnt <= '0;
        end else if (beat_acc) begin
            beat_cnt <= (beat_cnt == LAST_BEAT) ? '0 : beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            push_q <= 1'b0;
        end else begin
            push_q <= beat_acc && (beat_cnt == LAST_BEAT);
        end
    end

    // -----------------------------------------------------------------------
    // Plane words
    // -----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (beat_acc) begin
            case (beat_cnt)
                CNT_W'(0): y_data.y0 <= r.data;
                CNT_W'(1): y_data.y1 <= r.data;
                default: begin
                    uv_data.uv  <= r.data;
                    uv_data.err <= (r.resp != 2'b00);
                end
            endcase
        end
    end

    // Sticky only until the next OKAY beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_error <= 1'b0;
        end else if (beat_acc) begin
            rd_error <= (r.resp != 2'b00);
        end
    end

endmodule

/* rd_addr_gen.sv */
`include "yuv_defines.svh"

module rd_addr_gen
    import yuv_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic [`YUV_ADDR_W-1:0] base_addr,
    input  logic [`YUV_ADDR_W-1:0] frame_groups,
    input  logic                   burst_done,
    output axi_ar_t                ar,
    output logic                   ar_valid,
    input  logic                   ar_ready,
    output logic                   busy,
    output logic                   frame_done
);

    localparam int AW = `YUV_ADDR_W;
    localparam int OUT_W = $clog2(`YUV_MAX_OUTSTANDING + 1);
    localparam int BYTES_PER_BEAT = `YUV_DATA_W / 8;
    localparam logic [AW-1:0] GROUP_BYTES = AW'(`YUV_BURST_BEATS * BYTES_PER_BEAT);
    localparam logic [1:0] BURST_INCR = 2'b01;

    logic [AW-1:0]    addr_q;
    logic [AW-1:0]    issued_q;
    logic [AW-1:0]    done_q;
    logic [OUT_W-1:0] outstanding_q;
    logic [AW-1:0]    issued_nxt;
    logic [OUT_W-1:0] outstanding_nxt;
    logic             ar_xfer;
    logic             last_done;

    assign ar_xfer         = ar_valid && ar_ready;
    assign issued_nxt      = issued_q + AW'(ar_xfer);
    assign outstanding_nxt = outstanding_q + OUT_W'(ar_xfer) - OUT_W'(burst_done);
    // The completing burst of the frame ends it
    assign last_done       = busy && burst_done && (done_q + 1'b1 == frame_groups);

    // Fixed incrementing burst, only the address moves
    always_comb begin
        ar       = '0;
        ar.addr  = addr_q;
        ar.id    = '0;
        ar.len   = 8'(`YUV_BURST_BEATS - 1);
        ar.size  = 3'($clog2(BYTES_PER_BEAT));
        ar.burst = BURST_INCR;
    end

    // -----------------------------------------------------------------------
    // Frame control and AR issue
    // -----------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy          <= 1'b0;
            frame_done    <= 1'b0;
            ar_valid      <= 1'b0;
            addr_q        <= '0;
            issued_q      <= '0;
            done_q        <= '0;
            outstanding_q <= '0;
        end else begin
            frame_done <= 1'b0;
            if (!busy) begin
                if (start) begin
                    addr_q        <= base_addr;
                    issued_q      <= '0;
                    done_q        <= '0;
                    outstanding_q <= '0;
                    if (frame_groups != '0) begin
                        busy     <= 1'b1;
                        ar_valid <= 1'b1;
                    end else begin
                        frame_done <= 1'b1;
                    end
                end
            end else begin
                if (ar_xfer) begin
                    addr_q <= addr_q + GROUP_BYTES;
                end
                issued_q      <= issued_nxt;
                outstanding_q <= outstanding_nxt;
                // ar_valid may only change when idle or on a transfer
                if (!ar_valid || ar_xfer) begin
                    ar_valid <= (issued_nxt < frame_groups) &&
                                (outstanding_nxt < OUT_W'(`YUV_MAX_OUTSTANDING));
                end
                if (burst_done) begin
                    done_q <= done_q + 1'b1;
                end
                if (last_done) begin
                    busy       <= 1'b0;
                    frame_done <= 1'b1;
                    ar_valid   <= 1'b0;
                end
            end
        end
    end

endmodule

/* plane_fifo.sv */
module plane_fifo
    import yuv_pkg::*;
#(
    parameter type T     = y_pair_t,
    parameter int  DEPTH = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic push,
    input  T     push_data,
    input  logic pop,
    output T     pop_data,
    output logic full,
    output logic empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Wraps at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

endmodule

/* yuv_pkg.sv */
`include "yuv_defines.svh"

package yuv_pkg;

    // -----------------------------------------------------------------------
    // AXI4 read channel payloads
    // -----------------------------------------------------------------------

    typedef struct packed {
        logic [`YUV_ADDR_W-1:0] addr;
        logic [`YUV_ID_W-1:0]   id;
        logic [7:0]             len;
        logic [2:0]             size;
        logic [1:0]             burst;
    } axi_ar_t;

    typedef struct packed {
        logic [`YUV_DATA_W-1:0] data;
        logic [`YUV_ID_W-1:0]   id;
        logic [1:0]             resp;
        logic                   last;
    } axi_r_t;

    // -----------------------------------------------------------------------
    // Plane payloads
    // -----------------------------------------------------------------------

    typedef struct packed {
        logic [`YUV_DATA_W-1:0] y0;
        logic [`YUV_DATA_W-1:0] y1;
    } y_pair_t;

    // err is the response flag of the UV beat
    typedef struct packed {
        logic [`YUV_DATA_W-1:0] uv;
        logic                   err;
    } uv_word_t;

    typedef struct packed {
        logic [`YUV_DATA_W-1:0] y0;
        logic [`YUV_DATA_W-1:0] y1;
        logic [`YUV_DATA_W-1:0] uv;
    } yuv_group_t;

endpackage

/* yuv_defines.svh */
`ifndef YUV_DEFINES_SVH
`define YUV_DEFINES_SVH

// ---------------------------------------------------------------------------
// Data path and AXI widths
// ---------------------------------------------------------------------------

// One beat carries one plane word
`define YUV_DATA_W 32
`define YUV_ADDR_W 32
`define YUV_ID_W 2

// ---------------------------------------------------------------------------
// Frame fetch shape
// ---------------------------------------------------------------------------

// Y0, Y1 and UV words make up one group and one burst
`define YUV_BURST_BEATS 3
`define YUV_MAX_OUTSTANDING 2
// Entries per plane queue
`define YUV_FIFO_DEPTH 4

`endif
